// File: bench/id_stage_chk.sv
`default_nettype none
`timescale 1ns/100ps

module id_stage_chk (
	input wire logic            clk,
	input wire logic            rst_n_i,
	input wire id_pkg::aluop_t  aluop_i,
	input wire id_pkg::alusel_t alusel_i,
	input wire logic            wreg_i,
	input wire logic            branch_flag_i
);
	import id_pkg::*;

	int unsigned fail_count = 0;

	a_no_branch_in_reset: assert property (@(posedge clk) !rst_n_i |-> !branch_flag_i)
	else begin
		fail_count++;
		$error("branch request raised while reset is low");
	end

	// jumps never write a register
	a_jump_no_write: assert property (@(posedge clk) (alusel_i == SEL_JUMP) |-> !wreg_i)
	else begin
		fail_count++;
		$error("write enable set on a jump operation");
	end

	a_nop_after_reset: assert property (@(posedge clk) !rst_n_i |=> (aluop_i == ALU_NOP))
	else begin
		fail_count++;
		$error("operation not cleared one edge after reset");
	end

endmodule

`default_nettype wire

// File: bench/id_stage_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "id_defines.svh"

module id_stage_tb;
	import id_pkg::*;

	// directed tests take about 250 cycles
	localparam int          MAX_CYCLES = 2000;
	localparam logic [31:0] LFSR_SEED  = 32'h73f6383b;
	localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

	logic        clk;
	logic        rst_n_i;
	inst_t       inst_i;
	word_t       reg1_data_i;
	word_t       reg2_data_i;
	logic        ex_wreg_i;
	reg_addr_t   ex_wd_i;
	word_t       ex_wdata_i;
	logic        mem_wreg_i;
	reg_addr_t   mem_wd_i;
	word_t       mem_wdata_i;
	logic        reg1_read_o;
	logic        reg2_read_o;
	reg_addr_t   reg1_addr_o;
	reg_addr_t   reg2_addr_o;
	aluop_t      aluop_o;
	alusel_t     alusel_o;
	word_t       reg1_o;
	word_t       reg2_o;
	reg_addr_t   wd_o;
	logic        wreg_o;
	logic        branch_flag_o;
	word_t       target_addr_o;

	word_t       rf [0:31];
	logic [31:0] lfsr = LFSR_SEED;
	int          cycles = 0;
	string       test_name;

	id_stage_top DUT (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.inst_i        (inst_i),
		.reg1_data_i   (reg1_data_i),
		.reg2_data_i   (reg2_data_i),
		.ex_wreg_i     (ex_wreg_i),
		.ex_wd_i       (ex_wd_i),
		.ex_wdata_i    (ex_wdata_i),
		.mem_wreg_i    (mem_wreg_i),
		.mem_wd_i      (mem_wd_i),
		.mem_wdata_i   (mem_wdata_i),
		.reg1_read_o   (reg1_read_o),
		.reg2_read_o   (reg2_read_o),
		.reg1_addr_o   (reg1_addr_o),
		.reg2_addr_o   (reg2_addr_o),
		.aluop_o       (aluop_o),
		.alusel_o      (alusel_o),
		.reg1_o        (reg1_o),
		.reg2_o        (reg2_o),
		.wd_o          (wd_o),
		.wreg_o        (wreg_o),
		.branch_flag_o (branch_flag_o),
		.target_addr_o (target_addr_o)
	);

	bind id_stage_top id_stage_chk u_chk (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.aluop_i       (aluop_o),
		.alusel_i      (alusel_o),
		.wreg_i        (wreg_o),
		.branch_flag_i (branch_flag_o)
	);

	// register file answers in the same cycle
	assign reg1_data_i = rf[reg1_addr_o];
	assign reg2_data_i = rf[reg2_addr_o];

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end else if (DUT.u_chk.fail_count != 0) begin
			$display("a bound assertion on the DUT failed");
			$display("=== FAIL ===");
			$fatal(1, "assertion failure");
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t v;
		int    i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic inst_t reg_inst(input logic [7:0] op, input reg_addr_t d,
		input reg_addr_t s1, input reg_addr_t s2);
		inst_t w;
		w = '0;
		w[`ID_F_CLASS] = `ID_CLASS_DREG;
		w[`ID_F_OP]    = op;
		w[`ID_F_DEST]  = d;
		w[`ID_F_SRC1]  = s1;
		w[`ID_F_SRC2]  = s2;
		return w;
	endfunction

	function automatic inst_t imm_inst(input logic [7:0] op, input reg_addr_t d,
		input reg_addr_t s1, input word_t imm);
		inst_t w;
		w = '0;
		w[`ID_F_CLASS] = `ID_CLASS_SREG;
		w[`ID_F_OP]    = op;
		w[`ID_F_DEST]  = d;
		w[`ID_F_SRC1]  = s1;
		w[`ID_F_IMM]   = imm;
		return w;
	endfunction

	function automatic inst_t movi_inst(input logic [7:0] op, input reg_addr_t d, input word_t imm);
		inst_t w;
		w = '0;
		w[`ID_F_CLASS]  = `ID_CLASS_SREG;
		w[`ID_F_OP]     = op;
		w[`ID_F_DEST]   = d;
		w[`ID_F_MOVIMM] = imm;
		return w;
	endfunction

	function automatic inst_t jmp_inst(input word_t tgt);
		inst_t w;
		w = '0;
		w[`ID_F_CLASS] = `ID_CLASS_SREG;
		w[`ID_F_OP]    = `ID_OP_JMP;
		w[`ID_F_JTGT]  = tgt;
		return w;
	endfunction

	// unsigned compare for the six branch forms
	function automatic logic taken(input logic [7:0] op, input word_t a, input word_t b);
		case (op)
			`ID_OP_JE:  return a == b;
			`ID_OP_JNE: return a != b;
			`ID_OP_JG:  return a > b;
			`ID_OP_JL:  return a < b;
			`ID_OP_JNG: return a <= b;
			`ID_OP_JNL: return a >= b;
			default:    return 1'b0;
		endcase
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic drive(input inst_t inst, input logic ex_we, input reg_addr_t ex_a,
		input word_t ex_d, input logic mem_we, input reg_addr_t mem_a, input word_t mem_d);
		@(posedge clk);
		inst_i      <= inst;
		ex_wreg_i   <= ex_we;
		ex_wd_i     <= ex_a;
		ex_wdata_i  <= ex_d;
		mem_wreg_i  <= mem_we;
		mem_wd_i    <= mem_a;
		mem_wdata_i <= mem_d;
		@(negedge clk);
	endtask

	task automatic issue(input inst_t inst);
		drive(inst, 1'b0, '0, '0, 1'b0, '0, '0);
	endtask

	// registered outputs settle one edge later
	task automatic next_edge();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_ctrl(input aluop_t op, input alusel_t sel, input logic we);
		expect_eq("aluop", op, aluop_o);
		expect_eq("alusel", sel, alusel_o);
		expect_eq("wreg", we, wreg_o);
	endtask

	task automatic check_reads(input logic r1, input logic r2);
		expect_eq("reg1_read", r1, reg1_read_o);
		expect_eq("reg2_read", r2, reg2_read_o);
	endtask

	task automatic test_reset();
		test_name = "reset";
		@(negedge clk);
		check_reads(1'b0, 1'b0);
		expect_eq("branch", 0, branch_flag_o);
		expect_eq("aluop", ALU_NOP, aluop_o);
		expect_eq("wreg", 0, wreg_o);
		@(posedge clk);
		inst_i <= reg_inst(`ID_OP_ADD, 5'd3, 5'd4, 5'd5);
		@(negedge clk);
		check_reads(1'b0, 1'b0);
		expect_eq("branch", 0, branch_flag_o);
		repeat (13) @(posedge clk);
		@(posedge clk);
		rst_n_i <= 1'b1;
	endtask

	task automatic test_alu();
		logic [7:0] ops [0:9];
		aluop_t     aops [0:9];
		alusel_t    sels [0:9];
		logic [7:0] op;
		logic       unary;
		reg_addr_t  d;
		reg_addr_t  s1;
		reg_addr_t  s2;
		word_t      imm;
		inst_t      w;
		int         k;
		test_name = "alu";
		ops = '{`ID_OP_OR, `ID_OP_AND, `ID_OP_XOR, `ID_OP_NOT, `ID_OP_SHL,
			`ID_OP_SHR, `ID_OP_SAR, `ID_OP_MOV, `ID_OP_ADD, `ID_OP_SUB};
		aops = '{ALU_OR, ALU_AND, ALU_XOR, ALU_NOT, ALU_SHL,
			ALU_SHR, ALU_SAR, ALU_MOV, ALU_ADD, ALU_SUB};
		sels = '{SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_SHIFT,
			SEL_SHIFT, SEL_SHIFT, SEL_MOV, SEL_ARITH, SEL_ARITH};
		for (k = 0; k < 20; k++) begin
			op     = ops[k % 10];
			unary  = (op == `ID_OP_NOT) || (op == `ID_OP_MOV);
			d      = rand_bits(5);
			s1     = rand_bits(5);
			s2     = rand_bits(5);
			rf[s1] = rand_bits(32);
			rf[s2] = rand_bits(32);
			w = reg_inst(op, d, s1, s2);
			issue(w);
			check_reads(1'b1, !unary);
			expect_eq("reg1_addr", s1, reg1_addr_o);
			expect_eq("branch", 0, branch_flag_o);
			next_edge();
			check_ctrl(aops[k % 10], sels[k % 10], 1'b1);
			expect_eq("wd", d, wd_o);
			expect_eq("reg1", rf[s1], reg1_o);
			expect_eq("reg2", unary ? w[`ID_F_IMM] : rf[s2], reg2_o);
			// immediate class
			imm = rand_bits(32);
			w = unary ? movi_inst(op, d, imm) : imm_inst(op, d, s1, imm);
			issue(w);
			check_reads(!unary, 1'b0);
			next_edge();
			check_ctrl(aops[k % 10], sels[k % 10], 1'b1);
			expect_eq("wd", d, wd_o);
			expect_eq("reg1", unary ? imm : rf[s1], reg1_o);
			expect_eq("reg2", unary ? w[`ID_F_IMM] : imm, reg2_o);
		end
	endtask

	task automatic test_forward();
		inst_t w;
		test_name = "forward";
		rf[7] = 32'h1111_0001;
		rf[9] = 32'h2222_0002;
		w = reg_inst(`ID_OP_ADD, 5'd1, 5'd7, 5'd9);
		drive(w, 1'b1, 5'd7, 32'he0e0_0001, 1'b1, 5'd7, 32'ha0a0_0001);
		next_edge();
		expect_eq("ex over mem", 32'he0e0_0001, reg1_o);
		expect_eq("port two rf", rf[9], reg2_o);
		drive(w, 1'b1, 5'd12, 32'he0e0_0002, 1'b1, 5'd9, 32'ha0a0_0002);
		next_edge();
		expect_eq("port one rf", rf[7], reg1_o);
		expect_eq("mem only", 32'ha0a0_0002, reg2_o);
		drive(w, 1'b0, 5'd7, 32'he0e0_0003, 1'b1, 5'd7, 32'ha0a0_0003);
		next_edge();
		expect_eq("ex not writing", 32'ha0a0_0003, reg1_o);
		drive(w, 1'b1, 5'd12, 32'he0e0_0004, 1'b1, 5'd13, 32'ha0a0_0004);
		next_edge();
		expect_eq("no match reg1", rf[7], reg1_o);
		expect_eq("no match reg2", rf[9], reg2_o);
		// ports that do not read keep the immediate
		w = imm_inst(`ID_OP_ADD, 5'd1, 5'd7, 32'hf800_1234);
		drive(w, 1'b1, w[`ID_F_SRC2], 32'he0e0_0005, 1'b1, w[`ID_F_SRC2], 32'ha0a0_0005);
		next_edge();
		expect_eq("idle port two", 32'hf800_1234, reg2_o);
		w = movi_inst(`ID_OP_MOV, 5'd1, 32'h4567_89ab);
		drive(w, 1'b1, w[`ID_F_SRC1], 32'he0e0_0006, 1'b0, '0, '0);
		next_edge();
		expect_eq("idle port one", 32'h4567_89ab, reg1_o);
	endtask

	task automatic test_branch();
		logic [7:0] bops [0:5];
		aluop_t     bals [0:5];
		word_t      pa [0:8];
		word_t      pb [0:8];
		word_t      tgt;
		logic       t;
		int         p;
		int         c;
		test_name = "branch";
		bops = '{`ID_OP_JE, `ID_OP_JNE, `ID_OP_JG, `ID_OP_JL, `ID_OP_JNG, `ID_OP_JNL};
		bals = '{ALU_JE, ALU_JNE, ALU_JG, ALU_JL, ALU_JNG, ALU_JNL};
		for (p = 0; p < 4; p++) begin
			pa[p] = rand_bits(32);
			pb[p] = rand_bits(32);
		end
		pa[4] = rand_bits(32);
		pb[4] = pa[4];
		pa[5] = 32'h0;
		pb[5] = 32'h0;
		pa[6] = 32'h0;
		pb[6] = 32'hffff_ffff;
		pa[7] = 32'hffff_ffff;
		pb[7] = 32'h0;
		pa[8] = 32'h7fff_ffff;
		pb[8] = 32'h8000_0000;
		for (p = 0; p < 9; p++) begin
			rf[20] = pa[p];
			rf[21] = pb[p];
			for (c = 0; c < 6; c++) begin
				tgt = rand_bits(32);
				t   = taken(bops[c], pa[p], pb[p]);
				issue(imm_inst(bops[c], 5'd20, 5'd21, tgt));
				check_reads(1'b1, 1'b1);
				expect_eq("reg1_addr", 20, reg1_addr_o);
				expect_eq("reg2_addr", 21, reg2_addr_o);
				expect_eq("branch", t, branch_flag_o);
				if (t)
					expect_eq("target", tgt, target_addr_o);
				next_edge();
				check_ctrl(bals[c], SEL_JUMP, 1'b0);
			end
		end
	endtask

	task automatic test_jump();
		word_t tgt;
		word_t v;
		inst_t w;
		test_name = "jump";
		tgt = rand_bits(32);
		issue(jmp_inst(tgt));
		check_reads(1'b0, 1'b0);
		expect_eq("branch", 1, branch_flag_o);
		expect_eq("target", tgt, target_addr_o);
		next_edge();
		check_ctrl(ALU_JMP, SEL_JUMP, 1'b0);
		rf[14] = rand_bits(32);
		w = reg_inst(`ID_OP_JMP, 5'd2, 5'd14, 5'd0);
		issue(w);
		expect_eq("reg1_read", 1, reg1_read_o);
		expect_eq("branch", 1, branch_flag_o);
		expect_eq("reg target", rf[14], target_addr_o);
		next_edge();
		check_ctrl(ALU_JMP, SEL_JUMP, 1'b0);
		v = rand_bits(32);
		drive(w, 1'b1, 5'd14, v, 1'b1, 5'd14, ~v);
		expect_eq("branch", 1, branch_flag_o);
		expect_eq("fwd target", v, target_addr_o);
		next_edge();
		check_ctrl(ALU_JMP, SEL_JUMP, 1'b0);
	endtask

	task automatic test_cmov();
		logic [7:0] op;
		aluop_t     exp_op;
		word_t      v;
		logic       we;
		int         i;
		test_name = "cmov";
		rf[11] = rand_bits(32);
		for (i = 0; i < 4; i++) begin
			op     = i[1] ? `ID_OP_MOVN : `ID_OP_MOVZ;
			exp_op = i[1] ? ALU_MOVN : ALU_MOVZ;
			v      = i[0] ? (rand_bits(32) | 32'h1) : 32'h0;
			we     = i[1] ? (v != 0) : (v == 0);
			rf[10] = v;
			issue(reg_inst(op, 5'd6, 5'd10, 5'd11));
			next_edge();
			check_ctrl(exp_op, SEL_MOV, we);
			expect_eq("wd", 6, wd_o);
			expect_eq("reg1", v, reg1_o);
		end
		// zero from memory stage blocks MOVN
		drive(imm_inst(`ID_OP_MOVN, 5'd6, 5'd10, 32'h10), 1'b0, '0, '0, 1'b1, 5'd10, '0);
		next_edge();
		check_ctrl(ALU_MOVN, SEL_MOV, 1'b0);
	endtask

	task automatic test_unknown();
		inst_t w [0:2];
		int    i;
		test_name = "unknown";
		w[0] = reg_inst(8'h3f, 5'd1, 5'd2, 5'd3);
		w[1] = imm_inst(8'h0d, 5'd1, 5'd2, 32'h55);
		w[2] = reg_inst(`ID_OP_ADD, 5'd1, 5'd2, 5'd3);
		w[2][`ID_F_CLASS] = 4'h7;
		for (i = 0; i < 3; i++) begin
			issue(w[i]);
			check_reads(1'b0, 1'b0);
			expect_eq("branch", 0, branch_flag_o);
			next_edge();
			check_ctrl(ALU_NOP, SEL_NOP, 1'b0);
		end
	endtask

	initial begin
		int i;
		rst_n_i     = 1'b0;
		inst_i      = jmp_inst(32'h0000_0400);
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		for (i = 0; i < 32; i++)
			rf[i] = 32'h9e37_79b9 * (i + 1);
		test_reset();
		test_alu();
		test_forward();
		test_branch();
		test_jump();
		test_cmov();
		test_unknown();
		@(negedge clk);
		if (DUT.u_chk.fail_count != 0) begin
			$display("bound assertions reported %0d failures", DUT.u_chk.fail_count);
			$display("=== FAIL ===");
			$fatal(1, "assertion failures");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: hw/cond_resolve.sv
`default_nettype none
`timescale 1ns/100ps

`include "id_defines.svh"

module cond_resolve (
	input  wire id_pkg::word_t    op1_i,
	input  wire id_pkg::word_t    op2_i,
	input  wire id_pkg::aluop_t   aluop_i,
	input  wire logic             wreg_i,
	input  wire id_pkg::br_cond_t br_cond_i,
	input  wire id_pkg::word_t    br_imm_i,
	input  wire logic             br_reg_i,
	output logic                  wreg_o,
	output logic                  branch_flag_o,
	output id_pkg::word_t         target_addr_o
);
	import id_pkg::*;

	logic [`ID_WORD_W:0] diff;
	logic                lt;
	logic                eq;
	logic                op1_zero;

	// unsigned compare, borrow out of the extra bit means op1 < op2
	assign diff     = {1'b0, op1_i} - {1'b0, op2_i};
	assign lt       = diff[`ID_WORD_W];
	assign eq       = (diff == '0);
	assign op1_zero = (op1_i == '0);

	always_comb begin
		case (br_cond_i)
			BR_ALWAYS: branch_flag_o = 1'b1;
			BR_EQ:     branch_flag_o = eq;
			BR_NE:     branch_flag_o = ~eq;
			BR_GT:     branch_flag_o = ~lt & ~eq;
			BR_LT:     branch_flag_o = lt;
			BR_LE:     branch_flag_o = lt | eq;
			BR_GE:     branch_flag_o = ~lt;
			default:   branch_flag_o = 1'b0;
		endcase
	end

	// conditional moves depend on operand one
	always_comb begin
		case (aluop_i)
			ALU_MOVZ: wreg_o = wreg_i & op1_zero;
			ALU_MOVN: wreg_o = wreg_i & ~op1_zero;
			default:  wreg_o = wreg_i;
		endcase
	end

	assign target_addr_o = br_reg_i ? op1_i : br_imm_i;

endmodule

`default_nettype wire

// File: hw/id_ex_reg.sv
`default_nettype none
`timescale 1ns/100ps

module id_ex_reg (
	input  wire logic              clk,
	input  wire logic              rst_n_i,
	input  wire id_pkg::aluop_t    aluop_i,
	input  wire id_pkg::alusel_t   alusel_i,
	input  wire id_pkg::word_t     reg1_i,
	input  wire id_pkg::word_t     reg2_i,
	input  wire id_pkg::reg_addr_t wd_i,
	input  wire logic              wreg_i,
	output id_pkg::aluop_t         aluop_o,
	output id_pkg::alusel_t        alusel_o,
	output id_pkg::word_t          reg1_o,
	output id_pkg::word_t          reg2_o,
	output id_pkg::reg_addr_t      wd_o,
	output logic                   wreg_o
);
	import id_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			aluop_o  <= ALU_NOP;
			alusel_o <= SEL_NOP;
			reg1_o   <= '0;
			reg2_o   <= '0;
			wd_o     <= '0;
			wreg_o   <= 1'b0;
		end else begin
			aluop_o  <= aluop_i;
			alusel_o <= alusel_i;
			reg1_o   <= reg1_i;
			reg2_o   <= reg2_i;
			wd_o     <= wd_i;
			wreg_o   <= wreg_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/id_pkg.sv
`default_nettype none

`include "id_defines.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0]  word_t;
	typedef logic [`ID_INST_W-1:0]  inst_t;
	typedef logic [`ID_RADDR_W-1:0] reg_addr_t;

	// operation codes follow the opcode values
	typedef enum logic [7:0] {
		ALU_NOP  = 8'h00,
		ALU_OR   = `ID_OP_OR,
		ALU_AND  = `ID_OP_AND,
		ALU_XOR  = `ID_OP_XOR,
		ALU_NOT  = `ID_OP_NOT,
		ALU_SHL  = `ID_OP_SHL,
		ALU_SHR  = `ID_OP_SHR,
		ALU_SAR  = `ID_OP_SAR,
		ALU_MOV  = `ID_OP_MOV,
		ALU_MOVZ = `ID_OP_MOVZ,
		ALU_MOVN = `ID_OP_MOVN,
		ALU_ADD  = `ID_OP_ADD,
		ALU_SUB  = `ID_OP_SUB,
		ALU_JMP  = `ID_OP_JMP,
		ALU_JE   = `ID_OP_JE,
		ALU_JNE  = `ID_OP_JNE,
		ALU_JG   = `ID_OP_JG,
		ALU_JL   = `ID_OP_JL,
		ALU_JNG  = `ID_OP_JNG,
		ALU_JNL  = `ID_OP_JNL
	} aluop_t;

	typedef enum logic [2:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_MOV,
		SEL_ARITH,
		SEL_JUMP
	} alusel_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE,
		BR_GT,
		BR_LT,
		BR_LE,
		BR_GE
	} br_cond_t;

endpackage

`default_nettype wire

// File: hw/id_stage_top.sv
`default_nettype none
`timescale 1ns/100ps

module id_stage_top (
	input  wire logic              clk,
	input  wire logic              rst_n_i,
	input  wire id_pkg::inst_t     inst_i,
	input  wire id_pkg::word_t     reg1_data_i,
	input  wire id_pkg::word_t     reg2_data_i,
	input  wire logic              ex_wreg_i,
	input  wire id_pkg::reg_addr_t ex_wd_i,
	input  wire id_pkg::word_t     ex_wdata_i,
	input  wire logic              mem_wreg_i,
	input  wire id_pkg::reg_addr_t mem_wd_i,
	input  wire id_pkg::word_t     mem_wdata_i,
	output logic                   reg1_read_o,
	output logic                   reg2_read_o,
	output id_pkg::reg_addr_t      reg1_addr_o,
	output id_pkg::reg_addr_t      reg2_addr_o,
	output id_pkg::aluop_t         aluop_o,
	output id_pkg::alusel_t        alusel_o,
	output id_pkg::word_t          reg1_o,
	output id_pkg::word_t          reg2_o,
	output id_pkg::reg_addr_t      wd_o,
	output logic                   wreg_o,
	output logic                   branch_flag_o,
	output id_pkg::word_t          target_addr_o
);
	import id_pkg::*;

	word_t     imm1;
	word_t     imm2;
	word_t     op1;
	word_t     op2;
	aluop_t    dec_aluop;
	alusel_t   dec_alusel;
	reg_addr_t dec_wd;
	logic      dec_wreg;
	logic      qual_wreg;
	br_cond_t  br_cond;
	word_t     br_imm;
	logic      br_reg;

	inst_decode u_decode (
		.rst_n_i    (rst_n_i),
		.inst_i     (inst_i),
		.rd1_en_o   (reg1_read_o),
		.rd2_en_o   (reg2_read_o),
		.rd1_addr_o (reg1_addr_o),
		.rd2_addr_o (reg2_addr_o),
		.imm1_o     (imm1),
		.imm2_o     (imm2),
		.aluop_o    (dec_aluop),
		.alusel_o   (dec_alusel),
		.wd_o       (dec_wd),
		.wreg_o     (dec_wreg),
		.br_cond_o  (br_cond),
		.br_imm_o   (br_imm),
		.br_reg_o   (br_reg)
	);

	operand_bypass u_bypass1 (
		.rd_en_i     (reg1_read_o),
		.rd_addr_i   (reg1_addr_o),
		.rf_data_i   (reg1_data_i),
		.imm_i       (imm1),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (op1)
	);

	operand_bypass u_bypass2 (
		.rd_en_i     (reg2_read_o),
		.rd_addr_i   (reg2_addr_o),
		.rf_data_i   (reg2_data_i),
		.imm_i       (imm2),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (op2)
	);

	cond_resolve u_resolve (
		.op1_i         (op1),
		.op2_i         (op2),
		.aluop_i       (dec_aluop),
		.wreg_i        (dec_wreg),
		.br_cond_i     (br_cond),
		.br_imm_i      (br_imm),
		.br_reg_i      (br_reg),
		.wreg_o        (qual_wreg),
		.branch_flag_o (branch_flag_o),
		.target_addr_o (target_addr_o)
	);

	id_ex_reg u_id_ex (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.aluop_i  (dec_aluop),
		.alusel_i (dec_alusel),
		.reg1_i   (op1),
		.reg2_i   (op2),
		.wd_i     (dec_wd),
		.wreg_i   (qual_wreg),
		.aluop_o  (aluop_o),
		.alusel_o (alusel_o),
		.reg1_o   (reg1_o),
		.reg2_o   (reg2_o),
		.wd_o     (wd_o),
		.wreg_o   (wreg_o)
	);

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
`default_nettype none
`timescale 1ns/100ps

`include "id_defines.svh"

module inst_decode (
	input  wire logic               rst_n_i,
	input  wire id_pkg::inst_t      inst_i,
	output logic                    rd1_en_o,
	output logic                    rd2_en_o,
	output id_pkg::reg_addr_t       rd1_addr_o,
	output id_pkg::reg_addr_t       rd2_addr_o,
	output id_pkg::word_t           imm1_o,
	output id_pkg::word_t           imm2_o,
	output id_pkg::aluop_t          aluop_o,
	output id_pkg::alusel_t         alusel_o,
	output id_pkg::reg_addr_t       wd_o,
	output logic                    wreg_o,
	output id_pkg::br_cond_t        br_cond_o,
	output id_pkg::word_t           br_imm_o,
	output logic                    br_reg_o
);
	import id_pkg::*;

	logic [`ID_CLASS_W-1:0] cls;
	logic [`ID_OP_W-1:0]    op;
	reg_addr_t              dest;
	reg_addr_t              src1;
	reg_addr_t              src2;
	word_t                  op_imm;
	word_t                  mov_imm;
	word_t                  jmp_tgt;
	alusel_t                op_sel;
	br_cond_t               cmp_cond;
	logic                   is_jmp;
	logic                   unary;
	logic                   valid;

	assign cls     = inst_i[`ID_F_CLASS];
	assign op      = inst_i[`ID_F_OP];
	assign dest    = inst_i[`ID_F_DEST];
	assign src1    = inst_i[`ID_F_SRC1];
	assign src2    = inst_i[`ID_F_SRC2];
	assign op_imm  = inst_i[`ID_F_IMM];
	assign mov_imm = inst_i[`ID_F_MOVIMM];
	assign jmp_tgt = inst_i[`ID_F_JTGT];

	assign is_jmp = (op == `ID_OP_JMP);
	// NOT and MOV take a single source
	assign unary  = (op == `ID_OP_NOT) || (op == `ID_OP_MOV);

	// result group per opcode, SEL_NOP marks an unknown opcode
	always_comb begin
		case (op)
			`ID_OP_OR, `ID_OP_AND, `ID_OP_XOR, `ID_OP_NOT: op_sel = SEL_LOGIC;
			`ID_OP_SHL, `ID_OP_SHR, `ID_OP_SAR: op_sel = SEL_SHIFT;
			`ID_OP_MOV, `ID_OP_MOVZ, `ID_OP_MOVN: op_sel = SEL_MOV;
			`ID_OP_ADD, `ID_OP_SUB: op_sel = SEL_ARITH;
			`ID_OP_JMP, `ID_OP_JE, `ID_OP_JNE, `ID_OP_JG, `ID_OP_JL,
			`ID_OP_JNG, `ID_OP_JNL: op_sel = SEL_JUMP;
			default: op_sel = SEL_NOP;
		endcase
	end

	always_comb begin
		case (op)
			`ID_OP_JE:  cmp_cond = BR_EQ;
			`ID_OP_JNE: cmp_cond = BR_NE;
			`ID_OP_JG:  cmp_cond = BR_GT;
			`ID_OP_JL:  cmp_cond = BR_LT;
			`ID_OP_JNG: cmp_cond = BR_LE;
			`ID_OP_JNL: cmp_cond = BR_GE;
			default:    cmp_cond = BR_NONE;
		endcase
	end

	always_comb begin
		rd1_en_o   = 1'b0;
		rd2_en_o   = 1'b0;
		rd1_addr_o = src1;
		rd2_addr_o = src2;
		imm1_o     = '0;
		imm2_o     = op_imm;
		wd_o       = dest;
		wreg_o     = 1'b0;
		br_cond_o  = BR_NONE;
		br_imm_o   = '0;
		br_reg_o   = 1'b0;
		valid      = 1'b0;
		case (cls)
			`ID_CLASS_SREG: begin
				if (cmp_cond != BR_NONE) begin
					// compare dest register against source one
					valid      = 1'b1;
					rd1_en_o   = 1'b1;
					rd2_en_o   = 1'b1;
					rd1_addr_o = dest;
					rd2_addr_o = src1;
					br_cond_o  = cmp_cond;
					br_imm_o   = op_imm;
				end else if (is_jmp) begin
					valid     = 1'b1;
					br_cond_o = BR_ALWAYS;
					br_imm_o  = jmp_tgt;
				end else if (op_sel != SEL_NOP) begin
					valid    = 1'b1;
					rd1_en_o = ~unary;
					imm1_o   = mov_imm;
					wreg_o   = 1'b1;
				end
			end
			`ID_CLASS_DREG: begin
				if (is_jmp) begin
					// target comes from forwarded operand one
					valid     = 1'b1;
					rd1_en_o  = 1'b1;
					br_cond_o = BR_ALWAYS;
					br_reg_o  = 1'b1;
				end else if (op_sel != SEL_NOP && cmp_cond == BR_NONE) begin
					valid    = 1'b1;
					rd1_en_o = 1'b1;
					rd2_en_o = ~unary;
					wreg_o   = 1'b1;
				end
			end
			default: begin
			end
		endcase
		aluop_o  = valid ? aluop_t'(op) : ALU_NOP;
		alusel_o = valid ? op_sel : SEL_NOP;
		if (!rst_n_i) begin
			rd1_en_o  = 1'b0;
			rd2_en_o  = 1'b0;
			wreg_o    = 1'b0;
			br_cond_o = BR_NONE;
		end
	end

endmodule

`default_nettype wire

// File: hw/operand_bypass.sv
`default_nettype none
`timescale 1ns/100ps

module operand_bypass (
	input  wire logic              rd_en_i,
	input  wire id_pkg::reg_addr_t rd_addr_i,
	input  wire id_pkg::word_t     rf_data_i,
	input  wire id_pkg::word_t     imm_i,
	input  wire logic              ex_wreg_i,
	input  wire id_pkg::reg_addr_t ex_wd_i,
	input  wire id_pkg::word_t     ex_wdata_i,
	input  wire logic              mem_wreg_i,
	input  wire id_pkg::reg_addr_t mem_wd_i,
	input  wire id_pkg::word_t     mem_wdata_i,
	output id_pkg::word_t          operand_o
);
	import id_pkg::*;

	logic  ex_hit;
	logic  mem_hit;
	word_t fwd_data;

	assign ex_hit  = rd_en_i & ex_wreg_i & (ex_wd_i == rd_addr_i);
	assign mem_hit = rd_en_i & mem_wreg_i & (mem_wd_i == rd_addr_i);

	// execute holds the younger result, so it wins over memory
	assign fwd_data = ex_hit ? ex_wdata_i : mem_wdata_i;

	always_comb begin
		if (ex_hit || mem_hit)
			operand_o = fwd_data;
		else if (rd_en_i)
			operand_o = rf_data_i;
		else
			operand_o = imm_i;
	end

endmodule

`default_nettype wire

// File: include/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// widths
`define ID_WORD_W   32
`define ID_INST_W   64
`define ID_RADDR_W  5
`define ID_CLASS_W  4
`define ID_OP_W     8

// instruction fields
`define ID_F_CLASS   63:60
`define ID_F_OP      59:52
`define ID_F_DEST    51:47
`define ID_F_SRC1    46:42
`define ID_F_SRC2    41:37
`define ID_F_IMM     41:10
`define ID_F_MOVIMM  46:15
`define ID_F_JTGT    51:20

// operand classes
`define ID_CLASS_SREG  4'h1
`define ID_CLASS_DREG  4'h2

// opcodes
`define ID_OP_OR    8'h01
`define ID_OP_AND   8'h02
`define ID_OP_XOR   8'h03
`define ID_OP_NOT   8'h04
`define ID_OP_SHL   8'h05
`define ID_OP_SHR   8'h06
`define ID_OP_SAR   8'h07
`define ID_OP_MOV   8'h08
`define ID_OP_MOVZ  8'h09
`define ID_OP_MOVN  8'h0a
`define ID_OP_ADD   8'h0b
`define ID_OP_SUB   8'h0c
`define ID_OP_JMP   8'h10
`define ID_OP_JE    8'h11
`define ID_OP_JNE   8'h12
`define ID_OP_JG    8'h13
`define ID_OP_JL    8'h14
`define ID_OP_JNG   8'h15
`define ID_OP_JNL   8'h16

`endif

// File: project.f
+incdir+include
hw/id_pkg.sv
hw/inst_decode.sv
hw/operand_bypass.sv
hw/cond_resolve.sv
hw/id_ex_reg.sv
hw/id_stage_top.sv
bench/id_stage_chk.sv
bench/id_stage_tb.sv
